//--- smpc_pkg.sv
package smpc_pkg;

	// Host bus byte addresses, formed as {A, 1'b1}
	localparam logic [6:0] ADDR_IREG0      = 7'h01;
	localparam logic [6:0] ADDR_IREG1      = 7'h03;
	localparam logic [6:0] ADDR_IREG2      = 7'h05;
	localparam logic [6:0] ADDR_IREG3      = 7'h07;
	localparam logic [6:0] ADDR_IREG4      = 7'h09;
	localparam logic [6:0] ADDR_IREG5      = 7'h0B;
	localparam logic [6:0] ADDR_IREG6      = 7'h0D;
	localparam logic [6:0] ADDR_COMREG     = 7'h1F;
	localparam logic [6:0] ADDR_OREG_FIRST = 7'h21;
	localparam logic [6:0] ADDR_OREG_LAST  = 7'h5F;
	localparam logic [6:0] ADDR_SR         = 7'h61;
	localparam logic [6:0] ADDR_SF         = 7'h63;

	localparam logic [5:0] OREG_BASE = 6'h10;	// A value of OREG0

	// Command codes
	localparam logic [7:0] CMD_MSHON   = 8'h00;
	localparam logic [7:0] CMD_SSHON   = 8'h02;
	localparam logic [7:0] CMD_SSHOFF  = 8'h03;
	localparam logic [7:0] CMD_SNDON   = 8'h06;
	localparam logic [7:0] CMD_SNDOFF  = 8'h07;
	localparam logic [7:0] CMD_CDON    = 8'h08;
	localparam logic [7:0] CMD_CDOFF   = 8'h09;
	localparam logic [7:0] CMD_INTBACK = 8'h10;
	localparam logic [7:0] CMD_SETTIME = 8'h16;
	localparam logic [7:0] CMD_SETSMEM = 8'h17;
	localparam logic [7:0] CMD_NMIREQ  = 8'h18;
	localparam logic [7:0] CMD_RESENAB = 8'h19;
	localparam logic [7:0] CMD_RESDISA = 8'h1A;

	// Wait counts in CE cycles
	localparam logic [19:0] WAIT_POWER   = 20'd120;
	localparam logic [19:0] WAIT_CD      = 20'd159;
	localparam logic [19:0] WAIT_SETTIME = 20'd279;
	localparam logic [19:0] WAIT_SETSMEM = 20'd159;
	localparam logic [19:0] WAIT_NMI     = 20'd127;

	localparam logic [7:0]  INTBACK_KEY           = 8'hF0;
	localparam logic [4:0]  OREG_LAST_IDX         = 5'd31;
	localparam logic [21:0] TICKS_PER_SEC_DEFAULT = 22'd4000000;

	typedef enum logic [4:0] {
		ST_IDLE  = 5'b00001,
		ST_START = 5'b00010,
		ST_WAIT  = 5'b00100,
		ST_EXEC  = 5'b01000,
		ST_END   = 5'b10000
	} cmd_state_t;

	localparam logic [2:0] SR_DONE_STATUS = 3'b010;	// SR[7:5] after status answer

endpackage

//--- smpc_rtc.sv
`timescale 1ns/1ps

module smpc_rtc #(
	parameter logic [21:0] TICKS_PER_SEC = smpc_pkg::TICKS_PER_SEC_DEFAULT
) (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        ce,
	input  logic        time_load,
	input  logic [7:0]  ireg0,
	input  logic [7:0]  ireg1,
	input  logic [7:0]  ireg2,
	input  logic [7:0]  ireg3,
	input  logic [7:0]  ireg4,
	input  logic [7:0]  ireg5,
	input  logic [7:0]  ireg6,
	output logic [7:0]  sec,
	output logic [7:0]  min,
	output logic [7:0]  hour,
	output logic [7:0]  days,
	output logic [7:0]  day_month,
	output logic [15:0] year
);

	import smpc_pkg::*;

	logic [21:0] pre_cnt;
	logic        sec_tick;
	logic [3:0]  wday;
	logic [3:0]  month;
	logic        day_end;

	function automatic logic [7:0] bcd_inc(input logic [7:0] v);
		logic [7:0] r;
		if (v[3:0] == 4'd9)
			r = {v[7:4] + 4'd1, 4'd0};
		else
			r = {v[7:4], v[3:0] + 4'd1};
		return r;
	endfunction

	assign sec_tick = ce && (pre_cnt == TICKS_PER_SEC - 22'd1);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pre_cnt <= '0;
		end else if (ce) begin
			pre_cnt <= sec_tick ? '0 : pre_cnt + 22'd1;	// Free running, load does not restart
		end
	end

	// Last day of the current month
	assign day_end = (month == 4'd2 && days == 8'h28) ||
		((month == 4'd4 || month == 4'd6 || month == 4'd9 || month == 4'd11) &&
		days == 8'h30) || days == 8'h31;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			sec <= 8'h00;
			min <= 8'h00;
			hour <= 8'h00;
			days <= 8'h01;
			wday <= 4'd0;
			month <= 4'd1;
			year <= 16'h2024;
		end else if (time_load) begin
			sec <= ireg6;
			min <= ireg5;
			hour <= ireg4;
			days <= ireg3;
			{wday, month} <= ireg2;
			year <= {ireg0, ireg1};
		end else if (sec_tick) begin
			if (sec == 8'h59) begin
				sec <= 8'h00;
				if (min == 8'h59) begin
					min <= 8'h00;
					if (hour == 8'h23) begin
						hour <= 8'h00;
						if (day_end) begin
							days <= 8'h01;
							if (month == 4'd12) begin
								month <= 4'd1;
								year <= year + 16'd1;	// Binary year
							end else begin
								month <= month + 4'd1;
							end
						end else begin
							days <= bcd_inc(days);
						end
					end else begin
						hour <= bcd_inc(hour);
					end
				end else begin
					min <= bcd_inc(min);
				end
			end else begin
				sec <= bcd_inc(sec);
			end
		end
	end

	assign day_month = {wday, month};

	a_sec_digit: assert property (@(posedge CLK) disable iff (!RST_N) sec[3:0] <= 4'd9)
		else $error("rtc seconds digit out of BCD range");

endmodule

//--- smpc_oreg_ram.sv
`timescale 1ns/1ps

module smpc_oreg_ram (
	input  logic       CLK,
	input  logic       we,
	input  logic [4:0] waddr,
	input  logic [7:0] wdata,
	input  logic [4:0] raddr,
	output logic [7:0] q
);

	import smpc_pkg::*;

	logic [7:0] mem [0:OREG_LAST_IDX];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	assign q = mem[raddr];	// Unregistered read

endmodule

//--- smpc_host_if.sv
`timescale 1ns/1ps

module smpc_host_if (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic [5:0] a,
	input  logic [7:0] di,
	input  logic       cs_n,
	input  logic       rw_n,
	input  logic       cmd_done,
	input  logic [2:0] sr_hi,
	input  logic [7:0] oreg_q,
	output logic [7:0] do_data,
	output logic       com_set,
	output logic [7:0] comreg,
	output logic [7:0] ireg0,
	output logic [7:0] ireg1,
	output logic [7:0] ireg2,
	output logic [7:0] ireg3,
	output logic [7:0] ireg4,
	output logic [7:0] ireg5,
	output logic [7:0] ireg6,
	output logic [4:0] oreg_raddr
);

	import smpc_pkg::*;

	logic [6:0] addr;
	logic       rw_n_old;
	logic       cs_n_old;
	logic       wr_edge;
	logic       rd_edge;
	logic       sf;

	assign addr = {a, 1'b1};
	assign wr_edge = !rw_n && rw_n_old && !cs_n;
	assign rd_edge = !cs_n && cs_n_old && rw_n;
	assign oreg_raddr = 5'(a - OREG_BASE);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old <= 1'b1;
			cs_n_old <= 1'b1;
			com_set <= 1'b0;
			comreg <= '0;
			ireg0 <= '0;
			ireg1 <= '0;
			ireg2 <= '0;
			ireg3 <= '0;
			ireg4 <= '0;
			ireg5 <= '0;
			ireg6 <= '0;
			sf <= 1'b0;
			do_data <= '0;
		end else begin
			rw_n_old <= rw_n;
			cs_n_old <= cs_n;
			com_set <= 1'b0;
			if (cmd_done) sf <= 1'b0;

			if (wr_edge) begin
				case (addr)
					ADDR_IREG0: ireg0 <= di;
					ADDR_IREG1: ireg1 <= di;
					ADDR_IREG2: ireg2 <= di;
					ADDR_IREG3: ireg3 <= di;
					ADDR_IREG4: ireg4 <= di;
					ADDR_IREG5: ireg5 <= di;
					ADDR_IREG6: ireg6 <= di;
					ADDR_COMREG: begin
						comreg <= di;
						com_set <= 1'b1;
					end
					ADDR_SF: if (di[0]) sf <= 1'b1;
					default: ;
				endcase
			end

			if (rd_edge) begin
				if (addr >= ADDR_OREG_FIRST && addr <= ADDR_OREG_LAST)
					do_data <= oreg_q;
				else if (addr == ADDR_SR)
					do_data <= {sr_hi, 1'b0, ireg1[7:4]};	// Reset button bit reads 0
				else if (addr == ADDR_SF)
					do_data <= {7'b0, sf};
				else
					do_data <= '0;
			end
		end
	end

	a_com_set_pulse: assert property (@(posedge CLK) disable iff (!RST_N) com_set |=> !com_set)
		else $error("com_set held longer than one clock");

endmodule

//--- smpc_cmd_seq.sv
`timescale 1ns/1ps

module smpc_cmd_seq (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        ce,
	input  logic        mres_n,
	input  logic        time_set,
	input  logic [3:0]  ac,
	input  logic        com_set,
	input  logic [7:0]  comreg,
	input  logic [7:0]  ireg0,
	input  logic [7:0]  ireg1,
	input  logic [7:0]  ireg2,
	input  logic [7:0]  ireg3,
	input  logic [7:0]  sec,
	input  logic [7:0]  min,
	input  logic [7:0]  hour,
	input  logic [7:0]  days,
	input  logic [7:0]  day_month,
	input  logic [15:0] year,
	output logic        MSHRES_N,
	output logic        MSHNMI_N,
	output logic        SSHRES_N,
	output logic        SSHNMI_N,
	output logic        SYSRES_N,
	output logic        SNDRES_N,
	output logic        CDRES_N,
	output logic        MIRQ_N,
	output logic        time_load,
	output logic        cmd_done,
	output logic [2:0]  sr_hi,
	output logic        oreg_we,
	output logic [4:0]  oreg_waddr,
	output logic [7:0]  oreg_wdata
);

	import smpc_pkg::*;

	cmd_state_t  state;
	logic [7:0]  cmd;
	logic        pending;
	logic        req;
	logic        consume;
	logic        run;
	logic [19:0] wait_cnt;
	logic [4:0]  oreg_cnt;
	logic        resd;
	logic        ste;
	logic [7:0]  smem [4];
	logic        intback;
	logic [7:0]  status_byte;

	assign run = ce && mres_n;
	assign req = pending || com_set;
	assign consume = run && state == ST_IDLE && req;
	assign intback = cmd == CMD_INTBACK;

	// Command write kept until ST_IDLE consumes it
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) pending <= 1'b0;
		else pending <= req && !consume;
	end

	always_comb begin
		case (oreg_cnt)
			5'd0: status_byte = {ste, resd, 6'b0};
			5'd1: status_byte = year[15:8];
			5'd2: status_byte = year[7:0];
			5'd3: status_byte = day_month;
			5'd4: status_byte = days;
			5'd5: status_byte = hour;
			5'd6: status_byte = min;
			5'd7: status_byte = sec;
			5'd9: status_byte = {4'b0, ac};
			5'd10: status_byte = {4'b0011, ~MSHNMI_N, 1'b1, ~SYSRES_N, ~SNDRES_N};
			5'd11: status_byte = {1'b0, ~CDRES_N, 6'b0};
			5'd12: status_byte = smem[0];
			5'd13: status_byte = smem[1];
			5'd14: status_byte = smem[2];
			5'd15: status_byte = smem[3];
			OREG_LAST_IDX: status_byte = cmd;
			default: status_byte = 8'h00;
		endcase
	end

	assign oreg_we = run && state == ST_EXEC;
	assign oreg_waddr = intback ? oreg_cnt : OREG_LAST_IDX;
	assign oreg_wdata = intback ? status_byte : cmd;
	assign time_load = run && state == ST_EXEC && cmd == CMD_SETTIME;
	assign cmd_done = run && state == ST_END;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= ST_IDLE;
			cmd <= '0;
			wait_cnt <= '0;
			oreg_cnt <= '0;
			MSHRES_N <= 1'b0;
			MSHNMI_N <= 1'b0;
			SSHRES_N <= 1'b0;
			SSHNMI_N <= 1'b0;
			SYSRES_N <= 1'b0;
			SNDRES_N <= 1'b0;
			CDRES_N <= 1'b0;
			MIRQ_N <= 1'b1;
			resd <= 1'b1;
			ste <= 1'b0;
			sr_hi <= '0;
		end else if (!mres_n) begin
			MSHRES_N <= 1'b1;
			MSHNMI_N <= 1'b1;
			SSHRES_N <= 1'b0;
			SSHNMI_N <= 1'b1;
			SYSRES_N <= 1'b1;
			SNDRES_N <= 1'b0;
			CDRES_N <= 1'b1;
			MIRQ_N <= 1'b1;
			resd <= 1'b1;
			ste <= time_set;
			sr_hi <= '0;
		end else if (ce) begin
			case (state)
				ST_IDLE: begin
					MIRQ_N <= 1'b1;
					if (consume) begin
						cmd <= comreg;
						oreg_cnt <= '0;
						state <= ST_START;
					end
				end
				ST_START: begin
					sr_hi <= '0;
					state <= ST_WAIT;
					case (cmd)
						CMD_MSHON, CMD_SSHON, CMD_SSHOFF,
						CMD_SNDON, CMD_SNDOFF: wait_cnt <= WAIT_POWER;
						CMD_CDON, CMD_CDOFF: wait_cnt <= WAIT_CD;
						CMD_SETTIME: wait_cnt <= WAIT_SETTIME;
						CMD_SETSMEM: wait_cnt <= WAIT_SETSMEM;
						CMD_NMIREQ, CMD_RESENAB, CMD_RESDISA: wait_cnt <= WAIT_NMI;
						CMD_INTBACK: begin
							if (ireg2 == INTBACK_KEY && ireg0[0]) state <= ST_EXEC;
							else state <= ST_END;	// No answer, OREGs untouched
						end
						default: state <= ST_EXEC;
					endcase
				end
				ST_WAIT: begin
					if (wait_cnt == '0) state <= ST_EXEC;
					else wait_cnt <= wait_cnt - 20'd1;
				end
				ST_EXEC: begin
					state <= ST_END;
					case (cmd)
						CMD_MSHON: begin
							MSHRES_N <= 1'b1;
							MSHNMI_N <= 1'b1;
						end
						CMD_SSHON: begin
							SSHRES_N <= 1'b1;
							SSHNMI_N <= 1'b1;
						end
						CMD_SSHOFF: begin
							SSHRES_N <= 1'b0;
							SSHNMI_N <= 1'b1;
						end
						CMD_SNDON: SNDRES_N <= 1'b1;
						CMD_SNDOFF: SNDRES_N <= 1'b0;
						CMD_CDON: CDRES_N <= 1'b1;
						CMD_CDOFF: CDRES_N <= 1'b0;
						CMD_SETTIME: ste <= 1'b1;
						CMD_NMIREQ: MSHNMI_N <= 1'b0;
						CMD_RESENAB: resd <= 1'b0;
						CMD_RESDISA: resd <= 1'b1;
						CMD_INTBACK: begin
							oreg_cnt <= oreg_cnt + 5'd1;
							if (oreg_cnt == OREG_LAST_IDX) begin
								MIRQ_N <= 1'b0;
								sr_hi <= SR_DONE_STATUS;
							end else begin
								state <= ST_EXEC;	// One status byte per CE
							end
						end
						default: ;
					endcase
				end
				ST_END: begin
					if (cmd == CMD_NMIREQ) MSHNMI_N <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Battery backed, survives reset
	always_ff @(posedge CLK) begin
		if (run && state == ST_EXEC && cmd == CMD_SETSMEM) begin
			smem[0] <= ireg0;
			smem[1] <= ireg1;
			smem[2] <= ireg2;
			smem[3] <= ireg3;
		end
	end

	a_state_onehot: assert property (@(posedge CLK) disable iff (!RST_N) $onehot(state))
		else $error("command state not one-hot");
	a_we_exec: assert property (@(posedge CLK) disable iff (!RST_N)
		oreg_we |=> state == ST_END || (state == ST_EXEC && intback))
		else $error("oreg write outside an ST_EXEC burst");

endmodule

//--- smpc.sv
`timescale 1ns/1ps

module smpc #(
	parameter logic [21:0] TICKS_PER_SEC = smpc_pkg::TICKS_PER_SEC_DEFAULT
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       CE,
	input  logic       MRES_N,
	input  logic       TIME_SET,
	input  logic [3:0] AC,
	input  logic [6:1] A,
	input  logic [7:0] DI,
	output logic [7:0] DO,
	input  logic       CS_N,
	input  logic       RW_N,
	output logic       MSHRES_N,
	output logic       MSHNMI_N,
	output logic       SSHRES_N,
	output logic       SSHNMI_N,
	output logic       SYSRES_N,
	output logic       SNDRES_N,
	output logic       CDRES_N,
	output logic       MIRQ_N
);

	logic        com_set;
	logic        cmd_done;
	logic        time_load;
	logic [7:0]  comreg;
	logic [7:0]  ireg0, ireg1, ireg2, ireg3, ireg4, ireg5, ireg6;
	logic [2:0]  sr_hi;
	logic        oreg_we;
	logic [4:0]  oreg_waddr;
	logic [7:0]  oreg_wdata;
	logic [4:0]  oreg_raddr;
	logic [7:0]  oreg_q;
	logic [7:0]  sec, min, hour, days, day_month;
	logic [15:0] year;

	smpc_host_if u_host_if (
		.CLK(CLK), .RST_N(RST_N), .a(A), .di(DI), .cs_n(CS_N), .rw_n(RW_N),
		.cmd_done(cmd_done), .sr_hi(sr_hi), .oreg_q(oreg_q), .do_data(DO),
		.com_set(com_set), .comreg(comreg), .ireg0(ireg0), .ireg1(ireg1),
		.ireg2(ireg2), .ireg3(ireg3), .ireg4(ireg4), .ireg5(ireg5), .ireg6(ireg6),
		.oreg_raddr(oreg_raddr)
	);

	smpc_cmd_seq u_cmd_seq (
		.CLK(CLK), .RST_N(RST_N), .ce(CE), .mres_n(MRES_N), .time_set(TIME_SET), .ac(AC),
		.com_set(com_set), .comreg(comreg), .ireg0(ireg0), .ireg1(ireg1), .ireg2(ireg2),
		.ireg3(ireg3), .sec(sec), .min(min), .hour(hour), .days(days),
		.day_month(day_month), .year(year), .MSHRES_N(MSHRES_N), .MSHNMI_N(MSHNMI_N),
		.SSHRES_N(SSHRES_N), .SSHNMI_N(SSHNMI_N), .SYSRES_N(SYSRES_N), .SNDRES_N(SNDRES_N),
		.CDRES_N(CDRES_N), .MIRQ_N(MIRQ_N), .time_load(time_load), .cmd_done(cmd_done),
		.sr_hi(sr_hi), .oreg_we(oreg_we), .oreg_waddr(oreg_waddr), .oreg_wdata(oreg_wdata)
	);

	smpc_rtc #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_rtc (
		.CLK(CLK), .RST_N(RST_N), .ce(CE), .time_load(time_load),
		.ireg0(ireg0), .ireg1(ireg1), .ireg2(ireg2), .ireg3(ireg3),
		.ireg4(ireg4), .ireg5(ireg5), .ireg6(ireg6), .sec(sec), .min(min),
		.hour(hour), .days(days), .day_month(day_month), .year(year)
	);

	smpc_oreg_ram u_oreg_ram (
		.CLK(CLK), .we(oreg_we), .waddr(oreg_waddr), .wdata(oreg_wdata),
		.raddr(oreg_raddr), .q(oreg_q)
	);

endmodule

//--- tb_smpc.sv
`timescale 1ns/1ps

module tb_smpc;

	import smpc_pkg::*;

	localparam int TPS = 400;
	localparam logic [7:0] POWER_CMDS [9] = '{CMD_MSHON, CMD_SSHON, CMD_SSHOFF, CMD_SNDON,
		CMD_SNDOFF, CMD_CDON, CMD_CDOFF, CMD_RESENAB, CMD_RESDISA};

	logic       CLK;
	logic       RST_N;
	logic       CE;
	logic       MRES_N;
	logic       TIME_SET;
	logic [3:0] AC;
	logic [6:1] A;
	logic [7:0] DI;
	logic [7:0] DO;
	logic       CS_N;
	logic       RW_N;
	logic       MSHRES_N;
	logic       MSHNMI_N;
	logic       SSHRES_N;
	logic       SSHNMI_N;
	logic       SYSRES_N;
	logic       SNDRES_N;
	logic       CDRES_N;
	logic       MIRQ_N;

	logic [31:0] ce_lfsr = 32'hbc5d;
	logic [31:0] stim_lfsr = 32'hbc5d;
	logic [1:0]  ce_bits;
	int          ce_count = 0;
	int          mirq_falls = 0;
	int          ticks_at_intback;
	int          load_ticks;

	// Model state
	logic       m_mshres;
	logic       m_sshres;
	logic       m_sndres;
	logic       m_cdres;
	logic       m_resd;
	logic       m_ste;
	logic [2:0] m_sr_hi;
	logic [7:0] m_ireg [7];
	logic [7:0] m_smem [4];
	logic [7:0] oreg_rd [32];
	logic [7:0] oreg_snap [32];
	int         set_tm [6];	// sec, min, hour, day, month, year
	int         exp_tm [6];

	smpc #(.TICKS_PER_SEC(22'd400)) dut (
		.CLK(CLK), .RST_N(RST_N), .CE(CE), .MRES_N(MRES_N), .TIME_SET(TIME_SET), .AC(AC),
		.A(A), .DI(DI), .DO(DO), .CS_N(CS_N), .RW_N(RW_N), .MSHRES_N(MSHRES_N),
		.MSHNMI_N(MSHNMI_N), .SSHRES_N(SSHRES_N), .SSHNMI_N(SSHNMI_N), .SYSRES_N(SYSRES_N),
		.SNDRES_N(SNDRES_N), .CDRES_N(CDRES_N), .MIRQ_N(MIRQ_N)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		else
			return s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], stim_lfsr[0]};
			stim_lfsr = lfsr_step(stim_lfsr);
		end
		return r;
	endfunction

	// CE high in three of four cycles, counted like the RTC prescaler
	initial begin
		CE = 1'b0;
		forever begin
			@(posedge CLK);
			if (RST_N && CE) ce_count = ce_count + 1;
			ce_bits[0] = ce_lfsr[0];
			ce_lfsr = lfsr_step(ce_lfsr);
			ce_bits[1] = ce_lfsr[0];
			ce_lfsr = lfsr_step(ce_lfsr);
			CE <= ~&ce_bits;
		end
	end

	always @(negedge MIRQ_N) mirq_falls = mirq_falls + 1;

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s at %0t ns", reason, $time);
		$display("test failed");
		$fatal(1);
	endtask

	function automatic logic [6:0] oreg_addr(input int i);
		return {OREG_BASE + 6'(i), 1'b1};
	endfunction

	task automatic bus_write(input logic [6:0] addr, input logic [7:0] data);
		@(posedge CLK);
		A <= addr[6:1];
		DI <= data;
		CS_N <= 1'b0;
		RW_N <= 1'b0;
		repeat (3) @(posedge CLK);
		CS_N <= 1'b1;
		RW_N <= 1'b1;
		repeat (3 + rand_bits(2)) @(posedge CLK);
	endtask

	task automatic bus_read(input logic [6:0] addr, output logic [7:0] data);
		@(posedge CLK);
		A <= addr[6:1];
		RW_N <= 1'b1;
		CS_N <= 1'b0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		data = DO;
		@(posedge CLK);
		CS_N <= 1'b1;
		repeat (3 + rand_bits(2)) @(posedge CLK);
	endtask

	task automatic set_ireg(input int n, input logic [7:0] v);
		bus_write(ADDR_IREG0 + 7'(2 * n), v);
		m_ireg[n] = v;
	endtask

	task automatic run_cmd(input logic [7:0] code);
		logic [7:0] sf;
		int polls;
		bus_write(ADDR_SF, 8'h01);
		bus_write(ADDR_COMREG, code);
		polls = 0;
		sf = 8'h01;
		while (sf[0]) begin
			if (polls == 200) begin
				abort_run("timeout waiting for the command to clear SF");
			end else begin
				bus_read(ADDR_SF, sf);
				polls++;
			end
		end
		check("SF", 16'(sf), 16'h0000);
	endtask

	task automatic apply_model(input logic [7:0] code);
		case (code)
			CMD_MSHON: m_mshres = 1'b1;
			CMD_SSHON: m_sshres = 1'b1;
			CMD_SSHOFF: m_sshres = 1'b0;
			CMD_SNDON: m_sndres = 1'b1;
			CMD_SNDOFF: m_sndres = 1'b0;
			CMD_CDON: m_cdres = 1'b1;
			CMD_CDOFF: m_cdres = 1'b0;
			CMD_RESENAB: m_resd = 1'b0;
			CMD_RESDISA: m_resd = 1'b1;
			CMD_SETTIME: m_ste = 1'b1;
			CMD_SETSMEM: begin
				for (int i = 0; i < 4; i++) begin
					m_smem[i] = m_ireg[i];
				end
			end
			default: ;
		endcase
		m_sr_hi = 3'b000;
	endtask

	task automatic check_lines();
		@(negedge CLK);
		check("MSHRES_N", 16'(MSHRES_N), 16'(m_mshres));
		check("MSHNMI_N", 16'(MSHNMI_N), 16'h0001);
		check("SSHRES_N", 16'(SSHRES_N), 16'(m_sshres));
		check("SSHNMI_N", 16'(SSHNMI_N), 16'h0001);
		check("SYSRES_N", 16'(SYSRES_N), 16'h0001);
		check("SNDRES_N", 16'(SNDRES_N), 16'(m_sndres));
		check("CDRES_N", 16'(CDRES_N), 16'(m_cdres));
		check("MIRQ_N", 16'(MIRQ_N), 16'h0001);
	endtask

	task automatic check_status();
		logic [7:0] d;
		bus_read(ADDR_SR, d);
		check("SR", 16'(d), 16'({m_sr_hi, 1'b0, m_ireg[1][7:4]}));
	endtask

	task automatic do_cmd(input logic [7:0] code);
		logic [7:0] d;
		run_cmd(code);
		apply_model(code);
		check_lines();
		check_status();
		bus_read(oreg_addr(31), d);
		check("OREG31", 16'(d), 16'(code));
	endtask

	task automatic read_oregs();
		for (int i = 0; i < 32; i++) begin
			bus_read(oreg_addr(i), oreg_rd[i]);
		end
	endtask

	// Keep the status write clear of the next second tick
	task automatic wait_tick_margin();
		int guard;
		guard = 0;
		@(negedge CLK);
		while (ce_count % TPS > TPS - 100) begin
			if (guard == 1000) begin
				abort_run("timeout waiting for a quiet window before INTBACK");
			end else begin
				@(negedge CLK);
				guard++;
			end
		end
	endtask

	task automatic wait_ticks(input int target);
		int guard;
		guard = 0;
		@(negedge CLK);
		while (ce_count / TPS < target) begin
			if (guard == 4000) begin
				abort_run("timeout waiting for RTC seconds to elapse");
			end else begin
				@(negedge CLK);
				guard++;
			end
		end
	endtask

	task automatic do_intback(input logic answered);
		int falls;
		wait_tick_margin();
		ticks_at_intback = ce_count / TPS;
		falls = mirq_falls;
		run_cmd(CMD_INTBACK);
		m_sr_hi = answered ? 3'b010 : 3'b000;
		check("MIRQ_N pulses", 16'(mirq_falls - falls), 16'(answered));
		check_lines();
		check_status();
		read_oregs();
	endtask

	function automatic logic [7:0] exp_oreg(input int i);
		logic [7:0] v;
		v = 8'h00;
		if (i == 0) v = {m_ste, m_resd, 6'b0};
		else if (i == 9) v = {4'h0, AC};
		else if (i == 10) v = {4'b0011, 1'b0, 1'b1, 1'b0, ~m_sndres};	// NMI and SYSRES high
		else if (i == 11) v = {1'b0, ~m_cdres, 6'b0};
		else if (i >= 12 && i <= 15) v = m_smem[i - 12];
		else if (i == 31) v = CMD_INTBACK;
		return v;
	endfunction

	task automatic check_block();
		for (int i = 0; i < 32; i++) begin
			if (i == 0 || i >= 8) check($sformatf("OREG%0d", i), 16'(oreg_rd[i]),
				16'(exp_oreg(i)));
		end
	endtask

	function automatic int days_in_month(input int m);
		if (m == 2) return 28;
		else if (m == 4 || m == 6 || m == 9 || m == 11) return 30;
		else return 31;
	endfunction

	function automatic logic [7:0] to_bcd(input int v);
		return 8'((v / 10) * 16 + v % 10);
	endfunction

	task automatic load_exp(input int elapsed);
		exp_tm = set_tm;
		repeat (elapsed) begin
			exp_tm[0] = exp_tm[0] + 1;
			if (exp_tm[0] == 60) begin
				exp_tm[0] = 0;
				exp_tm[1] = exp_tm[1] + 1;
			end
			if (exp_tm[1] == 60) begin
				exp_tm[1] = 0;
				exp_tm[2] = exp_tm[2] + 1;
			end
			if (exp_tm[2] == 24) begin
				exp_tm[2] = 0;
				exp_tm[3] = exp_tm[3] + 1;
			end
			if (exp_tm[3] > days_in_month(exp_tm[4])) begin
				exp_tm[3] = 1;
				exp_tm[4] = exp_tm[4] + 1;
			end
			if (exp_tm[4] == 13) begin
				exp_tm[4] = 1;
				exp_tm[5] = exp_tm[5] + 1;
			end
		end
	endtask

	function automatic logic [7:0] exp_time_byte(input int i);
		logic [7:0] v;
		case (i)
			1: v = 8'(exp_tm[5] / 256);
			2: v = 8'(exp_tm[5] % 256);
			3: v = {4'h0, 4'(exp_tm[4])};
			4: v = to_bcd(exp_tm[3]);
			5: v = to_bcd(exp_tm[2]);
			6: v = to_bcd(exp_tm[1]);
			default: v = to_bcd(exp_tm[0]);
		endcase
		return v;
	endfunction

	// Load may have landed just before or after a tick
	task automatic check_time(input int elapsed);
		logic ok;
		ok = 1'b1;
		load_exp(elapsed);
		for (int i = 1; i <= 7; i++) begin
			if (oreg_rd[i] !== exp_time_byte(i)) ok = 1'b0;
		end
		if (!ok) begin
			load_exp(elapsed + 1);
			for (int i = 1; i <= 7; i++) begin
				check($sformatf("OREG%0d", i), 16'(oreg_rd[i]), 16'(exp_time_byte(i)));
			end
		end
	endtask

	initial begin
		logic [7:0] d;
		logic [7:0] key;
		int idx;

		RST_N = 1'b0;
		MRES_N = 1'b0;
		TIME_SET = 1'b0;
		A = '0;
		DI = '0;
		CS_N = 1'b1;
		RW_N = 1'b1;
		AC = 4'(rand_bits(4));
		m_mshres = 1'b1;
		m_sshres = 1'b0;
		m_sndres = 1'b0;
		m_cdres = 1'b1;
		m_resd = 1'b1;
		m_ste = 1'b0;
		m_sr_hi = 3'b000;
		for (int i = 0; i < 7; i++) begin
			m_ireg[i] = 8'h00;
		end

		repeat (9) @(posedge CLK);
		@(negedge CLK);
		check("MSHRES_N", 16'(MSHRES_N), 16'h0000);
		check("MSHNMI_N", 16'(MSHNMI_N), 16'h0000);
		check("SSHRES_N", 16'(SSHRES_N), 16'h0000);
		check("SSHNMI_N", 16'(SSHNMI_N), 16'h0000);
		check("SYSRES_N", 16'(SYSRES_N), 16'h0000);
		check("SNDRES_N", 16'(SNDRES_N), 16'h0000);
		check("CDRES_N", 16'(CDRES_N), 16'h0000);
		check("MIRQ_N", 16'(MIRQ_N), 16'h0001);
		check("DO", 16'(DO), 16'h0000);
		@(posedge CLK);
		RST_N <= 1'b1;
		repeat (5) @(posedge CLK);
		check_lines();	// Master reset levels
		@(posedge CLK);
		MRES_N <= 1'b1;
		bus_read(ADDR_SF, d);
		check("SF", 16'(d), 16'h0000);

		for (int n = 0; n < 16; n++) begin
			set_ireg(1, 8'(rand_bits(8)));
			idx = int'(rand_bits(4)) % 9;
			do_cmd(POWER_CMDS[idx]);
		end
		do_cmd(CMD_NMIREQ);

		for (int n = 0; n < 4; n++) begin
			set_ireg(n, 8'(rand_bits(8)));
		end
		do_cmd(CMD_SETSMEM);
		set_ireg(2, INTBACK_KEY);
		set_ireg(0, 8'(rand_bits(8)) | 8'h01);
		do_intback(1'b1);
		check_block();

		// Wrong key, then right key with the status bit clear
		for (int n = 0; n < 2; n++) begin
			oreg_snap = oreg_rd;
			if (n == 0) begin
				key = 8'(rand_bits(8));
				if (key == INTBACK_KEY) key = 8'h0F;
				set_ireg(2, key);
			end else begin
				set_ireg(2, INTBACK_KEY);
				set_ireg(0, 8'(rand_bits(8)) & 8'hFE);
			end
			do_intback(1'b0);
			for (int i = 0; i < 32; i++) begin
				check($sformatf("OREG%0d", i), 16'(oreg_rd[i]), 16'(oreg_snap[i]));
			end
		end

		set_ireg(6, 8'h58);
		set_ireg(5, 8'h59);
		set_ireg(4, 8'h23);
		set_ireg(3, 8'h31);
		set_ireg(2, 8'h0C);
		set_ireg(1, 8'hFF);
		set_ireg(0, 8'h1F);
		set_tm = '{58, 59, 23, 31, 12, 8191};
		do_cmd(CMD_SETTIME);
		@(negedge CLK);
		load_ticks = ce_count / TPS;
		set_ireg(2, INTBACK_KEY);
		set_ireg(0, 8'h01);
		wait_ticks(load_ticks + 2);	// Past midnight of the new year
		do_intback(1'b1);
		check_block();
		check_time(ticks_at_intback - load_ticks);

		$display("test passed");
		$finish;
	end

endmodule

//--- smpc.f
smpc_pkg.sv
smpc_rtc.sv
smpc_oreg_ram.sv
smpc_host_if.sv
smpc_cmd_seq.sv
smpc.sv
tb_smpc.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f smpc.f --top-module tb_smpc -o tb_smpc

run: build
	./obj_dir/tb_smpc

lint:
	verilator --lint-only -Wall --top-module smpc smpc_pkg.sv smpc_rtc.sv \
		smpc_oreg_ram.sv smpc_host_if.sv smpc_cmd_seq.sv smpc.sv

clean:
	rm -rf obj_dir
